// ==== tests/ddr_line_stim.txt ====
# test op addr(hex) data(256-bit hex, written or expected) app_traffic(1 = app_en expected)
# op: W write, R read, C read with calibration held low at first
1 R 00000000 0000000000000000000000000000000000000000000000000000000000000000 1
2 W 00000008 0123456789abcdeffedcba987654321000112233445566778899aabbccddeeff 1
3 R 00000008 0123456789abcdeffedcba987654321000112233445566778899aabbccddeeff 0
4 R 0000000c 0123456789abcdeffedcba987654321000112233445566778899aabbccddeeff 0
5 W 00000100 deadbeefcafef00d1234567890abcdefa5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 1
6 R 00000010 0000000000000000000000000000000000000000000000000000000000000000 1
7 R 00000008 0123456789abcdeffedcba987654321000112233445566778899aabbccddeeff 1
8 R 00000008 0123456789abcdeffedcba987654321000112233445566778899aabbccddeeff 0
9 W 00000008 ffffffff00000000aaaaaaaa5555555513579bdf02468acefedcba9801234567 1
10 R 0000000f ffffffff00000000aaaaaaaa5555555513579bdf02468acefedcba9801234567 0
11 R 00000100 deadbeefcafef00d1234567890abcdefa5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 1
12 C 00000200 0000000000000000000000000000000000000000000000000000000000000000 1
13 W 01fffff8 80000000000000017ffffffffffffffec3c3c3c33c3c3c3c0123012301230123 1
14 R 00000100 deadbeefcafef00d1234567890abcdefa5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 1
15 R 01fffff8 80000000000000017ffffffffffffffec3c3c3c33c3c3c3c0123012301230123 1
16 C 00000008 ffffffff00000000aaaaaaaa5555555513579bdf02468acefedcba9801234567 1
17 R 00000009 ffffffff00000000aaaaaaaa5555555513579bdf02468acefedcba9801234567 0

// ==== verilog.f ====
+incdir+include
logic/ddr_line_pkg.sv
logic/app_bus_if.sv
logic/line_sequencer.sv
logic/line_holder.sv
logic/ddr_line_top.sv
tests/app_mem_model.sv
tests/tb_ddr_line.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DDR line bridge testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing -f verilog.f --top-module tb_ddr_line \
    -Mdir obj_dir -o sim_tb_ddr_line
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb_ddr_line)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1

// ==== tests/tb_ddr_line.sv ====
// Testbench for the DDR line bridge replaying CPU accesses from a stimulus file
`timescale 1ns/1ps
`default_nettype none

`include "ddr_line_params.svh"

module tb_ddr_line;

    localparam int CLK_HALF        = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int CALIB_HOLD      = 20;
    localparam int LW              = `LINE_W;

    logic                       ui_clk = 1'b0;
    logic                       rst;
    logic                       ram_en;
    logic                       ram_write;
    logic [`RAM_ADDR_W-1:0]     ram_addr;
    logic [`LINE_W-1:0]         data_to_ram;
    logic                       ram_rdy;
    logic [`LINE_W-1:0]         data_from_ram;
    logic [`APP_ADDR_W-1:0]     app_addr;
    logic [2:0]                 app_cmd;
    logic                       app_en;
    logic [`BEAT_W-1:0]         app_wdf_data;
    logic                       app_wdf_wren;
    logic                       app_wdf_end;
    logic                       app_rdy;
    logic                       app_wdf_rdy;
    logic [`BEAT_W-1:0]         app_rd_data;
    logic                       app_rd_data_valid;
    logic                       init_calib_complete;
    logic                       hold_calib;

    // Stimulus table, one entry per access
    int                         test_no [$];
    logic [7:0]                 op_code [$];
    logic [`RAM_ADDR_W-1:0]     addr_tab [$];
    logic [`LINE_W-1:0]         data_tab [$];
    logic                       traffic_tab [$];

    int                         num_tests = 0;
    int                         error_count = 0;
    int                         pass_count = 0;
    int                         fail_count = 0;
    int                         errors_before;
    bit                         loaded;
    logic [`LINE_W-1:0]         got_data;
    logic                       saw_en;
    logic                       calib_leak;
    int                         end_count;

    always #(CLK_HALF) ui_clk = ~ui_clk;

    ddr_line_top ddr_line_top_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_en              (ram_en),
        .ram_write           (ram_write),
        .ram_addr            (ram_addr),
        .data_to_ram         (data_to_ram),
        .ram_rdy             (ram_rdy),
        .data_from_ram       (data_from_ram),
        .app_addr            (app_addr),
        .app_cmd             (app_cmd),
        .app_en              (app_en),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .app_wdf_end         (app_wdf_end),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .init_calib_complete (init_calib_complete)
    );

    app_mem_model app_mem_model_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .app_addr            (app_addr),
        .app_cmd             (app_cmd),
        .app_en              (app_en),
        .app_wdf_data        (app_wdf_data),
        .app_wdf_wren        (app_wdf_wren),
        .hold_calib          (hold_calib),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .app_rd_data         (app_rd_data),
        .app_rd_data_valid   (app_rd_data_valid),
        .init_calib_complete (init_calib_complete)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic compare_value(input string what, input logic [`LINE_W-1:0] got,
                                 input logic [`LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int                     fd;
        int                     n;
        int                     tno;
        int                     traffic;
        string                  text;
        logic [63:0]            op_txt;
        logic [`RAM_ADDR_W-1:0] addr;
        logic [`LINE_W-1:0]     data;
        ok = 1'b0;
        fd = $fopen("tests/ddr_line_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/ddr_line_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 1 && text[0] != "#") begin
                    n = $sscanf(text, "%d %s %h %h %d", tno, op_txt, addr, data, traffic);
                    if (n == 5) begin
                        test_no.push_back(tno);
                        op_code.push_back(op_txt[7:0]);
                        addr_tab.push_back(addr);
                        data_tab.push_back(data);
                        traffic_tab.push_back(traffic[0]);
                    end else begin
                        $display("Stimulus line could not be parsed: %s", text);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
            ok = (test_no.size() > 0);
            if (!ok) begin
                $display("The stimulus file holds no accesses");
            end
        end
    endtask

    // One CPU access, optionally with calibration held low for its first cycles
    task automatic run_access(input logic is_write, input logic [`RAM_ADDR_W-1:0] addr,
                              input logic [`LINE_W-1:0] wdata, input int calib_cycles,
                              output logic [`LINE_W-1:0] rdata, output logic en_seen,
                              output logic leak, output int end_beats);
        int   cyc;
        logic done;
        cyc       = 0;
        done      = 1'b0;
        en_seen   = 1'b0;
        leak      = 1'b0;
        end_beats = 0;
        rdata     = '0;
        @(negedge ui_clk);
        ram_en      = 1'b1;
        ram_write   = is_write;
        ram_addr    = addr;
        data_to_ram = wdata;
        hold_calib  = (calib_cycles > 0);
        while (!done) begin
            // Sample just before the rising edge
            #(CLK_HALF - 1);
            if (cyc < calib_cycles && (app_en || ram_rdy)) begin
                leak = 1'b1;
            end
            if (app_en) begin
                en_seen = 1'b1;
            end
            // Beats the memory takes as burst ends
            if (app_wdf_end && app_wdf_rdy) begin
                end_beats++;
            end
            if (ram_rdy) begin
                done  = 1'b1;
                rdata = data_from_ram;
            end
            @(negedge ui_clk);
            cyc++;
            if (cyc == calib_cycles) begin
                hold_calib = 1'b0;
            end
        end
        ram_en    = 1'b0;
        ram_write = 1'b0;
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h50eea50d));
        rst         = 1'b0;
        ram_en      = 1'b0;
        ram_write   = 1'b0;
        ram_addr    = '0;
        data_to_ram = '0;
        hold_calib  = 1'b0;
        load_stimulus(loaded);
        repeat (4) @(negedge ui_clk);
        rst = 1'b1;

        #(CLK_HALF - 1);
        errors_before = error_count;
        compare_value("app_en after reset", LW'(app_en), LW'(1'b0));
        compare_value("app_wdf_wren after reset", LW'(app_wdf_wren), LW'(1'b0));
        compare_value("ram_rdy after reset", LW'(ram_rdy), LW'(1'b0));
        if (error_count == errors_before) begin
            $display("Reset check passed");
        end else begin
            $display("Reset check failed");
        end

        if (loaded) begin
            num_tests = test_no.size();
            foreach (test_no[i]) begin
                errors_before = error_count;
                run_access(op_code[i] == "W", addr_tab[i], data_tab[i],
                           (op_code[i] == "C") ? CALIB_HOLD : 0,
                           got_data, saw_en, calib_leak, end_count);
                compare_value("app traffic during access", LW'(saw_en), LW'(traffic_tab[i]));
                // Two beats per written line, each one closing its burst
                compare_value("burst-end write beats", LW'(end_count),
                              LW'((op_code[i] == "W") ? 2 : 0));
                if (op_code[i] != "W") begin
                    compare_value("read data", got_data, data_tab[i]);
                end
                if (op_code[i] == "C") begin
                    compare_value("activity with calibration low", LW'(calib_leak), LW'(1'b0));
                end
                if (error_count == errors_before) begin
                    pass_count++;
                    $display("Test %0d (%s at %h) passed", test_no[i], op_code[i], addr_tab[i]);
                end else begin
                    fail_count++;
                    $display("Test %0d (%s at %h) failed", test_no[i], op_code[i], addr_tab[i]);
                end
            end
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, pass_count, fail_count, error_count);
        if (loaded && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of accesses
    initial begin
        wait (num_tests > 0);
        repeat (num_tests * CYCLES_PER_TEST) @(posedge ui_clk);
        $display("The run timed out after %0d cycles with an access still pending",
                 num_tests * CYCLES_PER_TEST);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/app_mem_model.sv ====
// Behavioral DDR app-interface memory with random stalls and variable read latency
`timescale 1ns/1ps
`default_nettype none

`include "ddr_line_params.svh"

module app_mem_model (
    input  logic                    ui_clk,
    input  logic                    rst,
    input  logic [`APP_ADDR_W-1:0]  app_addr,
    input  logic [2:0]              app_cmd,
    input  logic                    app_en,
    input  logic [`BEAT_W-1:0]      app_wdf_data,
    input  logic                    app_wdf_wren,
    input  logic                    hold_calib,
    output logic                    app_rdy,
    output logic                    app_wdf_rdy,
    output logic [`BEAT_W-1:0]      app_rd_data,
    output logic                    app_rd_data_valid,
    output logic                    init_calib_complete
);

    // Lines by line number, absent entries read as zero
    ddr_line_pkg::line_u        mem [logic [`TAG_W-1:0]];
    logic [`APP_ADDR_W-1:0]     wr_addr_q [$];
    logic [`BEAT_W-1:0]         wr_data_q [$];
    logic [`BEAT_W-1:0]         rd_data_q [$];
    longint                     rd_due_q [$];
    longint                     cycle;
    longint                     last_due;
    longint                     due;
    int                         lat;

    assign init_calib_complete = ~hold_calib;

    function automatic logic [`BEAT_W-1:0] read_beat(input logic [`APP_ADDR_W-1:0] addr);
        ddr_line_pkg::line_u entry;
        entry = '0;
        if (mem.exists(addr[`APP_ADDR_W-1:5])) begin
            entry = mem[addr[`APP_ADDR_W-1:5]];
        end
        return entry.beat[addr[4]];
    endfunction

    function automatic void write_beat(input logic [`APP_ADDR_W-1:0] addr,
                                       input logic [`BEAT_W-1:0] data);
        ddr_line_pkg::line_u entry;
        entry = '0;
        if (mem.exists(addr[`APP_ADDR_W-1:5])) begin
            entry = mem[addr[`APP_ADDR_W-1:5]];
        end
        entry.beat[addr[4]] = data;
        mem[addr[`APP_ADDR_W-1:5]] = entry;
    endfunction

    always @(posedge ui_clk) begin
        if (!rst) begin
            app_rdy           <= 1'b0;
            app_wdf_rdy       <= 1'b0;
            app_rd_data       <= '0;
            app_rd_data_valid <= 1'b0;
            wr_addr_q.delete();
            wr_data_q.delete();
            rd_data_q.delete();
            rd_due_q.delete();
            cycle    = 0;
            last_due = 0;
        end else begin
            // Read return, strictly in command order
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                app_rd_data       <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
                app_rd_data_valid <= 1'b1;
            end else begin
                app_rd_data_valid <= 1'b0;
            end

            if (app_en && app_rdy && app_cmd == ddr_line_pkg::APP_CMD_WRITE) begin
                wr_addr_q.push_back(app_addr);
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wr_data_q.push_back(app_wdf_data);
            end
            // Pair write commands with their data beats
            while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
                write_beat(wr_addr_q.pop_front(), wr_data_q.pop_front());
            end

            if (app_en && app_rdy && app_cmd == ddr_line_pkg::APP_CMD_READ) begin
                lat = 1 + int'($urandom % 6);
                due = cycle + longint'(lat);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rd_due_q.push_back(due);
                rd_data_q.push_back(read_beat(app_addr));
            end

            // Ready about three cycles in four
            app_rdy     <= ($urandom % 4) != 0;
            app_wdf_rdy <= ($urandom % 4) != 0;
            cycle = cycle + 1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ddr_line_top.sv ====
// DDR line bridge top joining the CPU line port to the app interface
`timescale 1ns/1ps
`default_nettype none

`include "ddr_line_params.svh"

module ddr_line_top (
    input  logic                        ui_clk,
    input  logic                        rst,

    // CPU port
    input  logic                        ram_en,
    input  logic                        ram_write,
    input  logic [`RAM_ADDR_W-1:0]      ram_addr,
    input  logic [`LINE_W-1:0]          data_to_ram,
    output logic                        ram_rdy,
    output logic [`LINE_W-1:0]          data_from_ram,

    // App interface of the DDR controller
    output logic [`APP_ADDR_W-1:0]      app_addr,
    output logic [2:0]                  app_cmd,
    output logic                        app_en,
    output logic [`BEAT_W-1:0]          app_wdf_data,
    output logic                        app_wdf_wren,
    output logic                        app_wdf_end,
    input  logic                        app_rdy,
    input  logic                        app_wdf_rdy,
    input  logic [`BEAT_W-1:0]          app_rd_data,
    input  logic                        app_rd_data_valid,
    input  logic                        init_calib_complete
);

    logic   hit;
    logic   store_line;
    logic   load_beat;
    logic   beat_sel;

    app_bus_if app_bus ();

    // --------------------------------------------------
    // App bus onto plain ports
    // --------------------------------------------------
    assign app_addr      = app_bus.addr;
    assign app_cmd       = app_bus.cmd;
    assign app_en        = app_bus.en;
    assign app_wdf_data  = app_bus.wdf_data;
    assign app_wdf_wren  = app_bus.wdf_wren;
    assign app_wdf_end   = app_bus.wdf_end;

    assign app_bus.rdy           = app_rdy;
    assign app_bus.wdf_rdy       = app_wdf_rdy;
    assign app_bus.rd_data       = app_rd_data;
    assign app_bus.rd_data_valid = app_rd_data_valid;

    line_sequencer line_sequencer_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_en              (ram_en),
        .ram_write           (ram_write),
        .ram_addr            (ram_addr),
        .data_to_ram         (data_to_ram),
        .init_calib_complete (init_calib_complete),
        .hit                 (hit),
        .ram_rdy             (ram_rdy),
        .store_line          (store_line),
        .load_beat           (load_beat),
        .beat_sel            (beat_sel),
        .app                 (app_bus.ctrl)
    );

    line_holder line_holder_i (
        .ui_clk              (ui_clk),
        .rst                 (rst),
        .ram_addr            (ram_addr),
        .data_to_ram         (data_to_ram),
        .store_line          (store_line),
        .load_beat           (load_beat),
        .beat_sel            (beat_sel),
        .app                 (app_bus.ctrl),
        .hit                 (hit),
        .data_from_ram       (data_from_ram)
    );

endmodule

`default_nettype wire

// ==== logic/line_holder.sv ====
// Line holder keeping the last line moved, its tag and a valid bit
`timescale 1ns/1ps
`default_nettype none

`include "ddr_line_params.svh"

module line_holder (
    input  logic                        ui_clk,
    input  logic                        rst,
    input  logic [`RAM_ADDR_W-1:0]      ram_addr,
    input  ddr_line_pkg::line_u         data_to_ram,
    input  logic                        store_line,
    input  logic                        load_beat,
    input  logic                        beat_sel,
    app_bus_if.ctrl                     app,
    output logic                        hit,
    output ddr_line_pkg::line_u         data_from_ram
);

    logic [`TAG_W-1:0]      tag;
    logic [`TAG_W-1:0]      line_no;
    logic                   valid;
    ddr_line_pkg::line_u    line_q;

    assign line_no = ram_addr[`TAG_W+2:3];
    assign hit     = valid & (tag == line_no);

    assign data_from_ram.line = line_q.line;

    // --------------------------------------------------
    // Valid bit
    // --------------------------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            valid <= 1'b0;
        end else if (store_line) begin
            valid <= 1'b1;
        end else if (load_beat) begin
            // Line is only whole again after beat 1
            valid <= beat_sel;
        end
    end

    // Line data and tag
    always_ff @(posedge ui_clk) begin
        if (store_line) begin
            line_q.line <= data_to_ram.line;
            tag         <= line_no;
        end else if (load_beat) begin
            line_q.beat[beat_sel] <= app.rd_data;
            if (beat_sel) begin
                tag <= line_no;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/line_sequencer.sv ====
// Line sequencer FSM turning a CPU line miss into two app beats or two reads
`timescale 1ns/1ps
`default_nettype none

`include "ddr_line_params.svh"

module line_sequencer (
    input  logic                        ui_clk,
    input  logic                        rst,
    input  logic                        ram_en,
    input  logic                        ram_write,
    input  logic [`RAM_ADDR_W-1:0]      ram_addr,
    input  ddr_line_pkg::line_u         data_to_ram,
    input  logic                        init_calib_complete,
    input  logic                        hit,
    output logic                        ram_rdy,
    output logic                        store_line,
    output logic                        load_beat,
    output logic                        beat_sel,
    app_bus_if.ctrl                     app
);

    ddr_line_pkg::seq_state_e   state;
    ddr_line_pkg::seq_state_e   state_next;
    logic                       rd_cmd_cnt;
    logic                       rd_beat_cnt;
    logic                       wr_done;
    logic                       beat_off;
    logic                       wr_accept;
    logic                       cpu_done;
    logic [`TAG_W-1:0]          line_no;

    assign line_no = ram_addr[`TAG_W+2:3];

    // Write beat taken only when command and data both go on the same edge
    assign wr_accept = init_calib_complete & app.rdy & app.wdf_rdy;

    // A write hit only counts once the line has gone out to DDR
    assign cpu_done = ram_en & hit & (~ram_write | wr_done);

    // --------------------------------------------------
    // App address and write data
    // --------------------------------------------------
    assign app.addr     = {line_no, beat_off, {(`APP_ADDR_W - `TAG_W - 1){1'b0}}};
    assign app.wdf_data = data_to_ram.beat[beat_off];
    assign app.wdf_end  = app.wdf_wren;

    // Read returns are taken in either read state, issue and collect overlap
    assign load_beat = app.rd_data_valid &
                       ((state == ddr_line_pkg::SEQ_RD_ISSUE) |
                        (state == ddr_line_pkg::SEQ_RD_COLLECT));
    assign beat_sel  = rd_beat_cnt;

    // --------------------------------------------------
    // Next state and app command
    // --------------------------------------------------
    always_comb begin
        state_next   = state;
        beat_off     = 1'b0;
        app.cmd      = ddr_line_pkg::APP_CMD_READ;
        app.en       = 1'b0;
        app.wdf_wren = 1'b0;
        store_line   = 1'b0;
        ram_rdy      = 1'b0;
        case (state)
            ddr_line_pkg::SEQ_IDLE: begin
                ram_rdy = cpu_done;
                if (ram_en && !cpu_done) begin
                    state_next = ram_write ? ddr_line_pkg::SEQ_WR_BEAT0
                                           : ddr_line_pkg::SEQ_RD_ISSUE;
                end
            end
            ddr_line_pkg::SEQ_WR_BEAT0: begin
                app.cmd      = ddr_line_pkg::APP_CMD_WRITE;
                app.en       = init_calib_complete & app.wdf_rdy;
                app.wdf_wren = init_calib_complete & app.rdy;
                if (wr_accept) begin
                    state_next = ddr_line_pkg::SEQ_WR_BEAT1;
                end
            end
            ddr_line_pkg::SEQ_WR_BEAT1: begin
                beat_off     = 1'b1;
                app.cmd      = ddr_line_pkg::APP_CMD_WRITE;
                app.en       = init_calib_complete & app.wdf_rdy;
                app.wdf_wren = init_calib_complete & app.rdy;
                if (wr_accept) begin
                    store_line = 1'b1;
                    state_next = ddr_line_pkg::SEQ_IDLE;
                end
            end
            ddr_line_pkg::SEQ_RD_ISSUE: begin
                beat_off = rd_cmd_cnt;
                app.en   = init_calib_complete;
                // Second read command accepted
                if (init_calib_complete && app.rdy && rd_cmd_cnt) begin
                    state_next = ddr_line_pkg::SEQ_RD_COLLECT;
                end
            end
            ddr_line_pkg::SEQ_RD_COLLECT: begin
                beat_off = 1'b1;
                if (app.rd_data_valid && rd_beat_cnt) begin
                    state_next = ddr_line_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_next = ddr_line_pkg::SEQ_IDLE;
            end
        endcase
    end

    // --------------------------------------------------
    // State and counters
    // --------------------------------------------------
    always_ff @(posedge ui_clk) begin
        if (!rst) begin
            state       <= ddr_line_pkg::SEQ_IDLE;
            rd_cmd_cnt  <= 1'b0;
            rd_beat_cnt <= 1'b0;
            wr_done     <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ddr_line_pkg::SEQ_RD_ISSUE && app.en && app.rdy) begin
                rd_cmd_cnt <= ~rd_cmd_cnt;
            end
            if (load_beat) begin
                rd_beat_cnt <= ~rd_beat_cnt;
            end
            // Cleared on the edge that completes the CPU access
            if (store_line) begin
                wr_done <= 1'b1;
            end else if (ram_rdy) begin
                wr_done <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/app_bus_if.sv ====
// App interface bundle between the bridge and the DDR controller user port
`timescale 1ns/1ps
`default_nettype none

`include "ddr_line_params.svh"

interface app_bus_if;

    // Command and write data, driven by the bridge
    logic [`APP_ADDR_W-1:0]   addr;
    ddr_line_pkg::app_cmd_e   cmd;
    logic                     en;
    logic [`BEAT_W-1:0]       wdf_data;
    logic                     wdf_wren;
    logic                     wdf_end;

    // Flow control and read return, driven by the memory side
    logic                     rdy;
    logic                     wdf_rdy;
    logic [`BEAT_W-1:0]       rd_data;
    logic                     rd_data_valid;

    modport ctrl (
        output addr, cmd, en, wdf_data, wdf_wren, wdf_end,
        input  rdy, wdf_rdy, rd_data, rd_data_valid
    );

    modport mem (
        input  addr, cmd, en, wdf_data, wdf_wren, wdf_end,
        output rdy, wdf_rdy, rd_data, rd_data_valid
    );

endinterface

`default_nettype wire

// ==== logic/ddr_line_pkg.sv ====
// DDR line bridge types shared by the sequencer, line holder and app bus
`default_nettype none

`include "ddr_line_params.svh"

package ddr_line_pkg;

    // App command encoding of the controller IP
    typedef enum logic [2:0] {
        APP_CMD_WRITE = 3'd0,
        APP_CMD_READ  = 3'd1
    } app_cmd_e;

    // One CPU line, also seen as two app beats (beat 0 is the low half)
    typedef union packed {
        logic [`LINE_W-1:0]         line;
        logic [1:0][`BEAT_W-1:0]    beat;
    } line_u;

    typedef enum logic [2:0] {
        SEQ_IDLE       = 3'd0,
        SEQ_WR_BEAT0   = 3'd1,
        SEQ_WR_BEAT1   = 3'd2,
        SEQ_RD_ISSUE   = 3'd3,
        SEQ_RD_COLLECT = 3'd4
    } seq_state_e;

endpackage

`default_nettype wire

// ==== include/ddr_line_params.svh ====
// DDR line bridge width parameters for the CPU port, the line and the app bus
`ifndef DDR_LINE_PARAMS_SVH
`define DDR_LINE_PARAMS_SVH

// CPU side
`define RAM_ADDR_W 30
`define LINE_W 256

// App interface side
`define BEAT_W 128
`define APP_ADDR_W 27

// Line number taken from CPU address bits 24 down to 3
`define TAG_W 22

`endif
